/* core_defines_macros.svh */
`ifndef CORE_DEFINES_MACROS_SVH
`define CORE_DEFINES_MACROS_SVH

// Word and field widths
`define DATA_WIDTH      32
`define GPR_ADDR_WIDTH  5
`define ALU_OP_WIDTH    8
`define ALU_SEL_WIDTH   3

// 3R format opcodes, instr[31:15]
`define EXE_ADD_W       17'h00020
`define EXE_SUB_W       17'h00022
`define EXE_SLT         17'h00024
`define EXE_SLTU        17'h00025
`define EXE_NOR         17'h00028
`define EXE_AND         17'h00029
`define EXE_OR          17'h0002a
`define EXE_XOR         17'h0002b
`define EXE_ORN         17'h0002c
`define EXE_ANDN        17'h0002d
`define EXE_SLL_W       17'h0002e
`define EXE_SRL_W       17'h0002f
`define EXE_SRA_W       17'h00030
`define EXE_MUL_W       17'h00038
`define EXE_MULH_W      17'h00039
`define EXE_MULH_WU     17'h0003a
`define EXE_DIV_W       17'h00040
`define EXE_MOD_W       17'h00041
`define EXE_DIV_WU      17'h00042
`define EXE_MOD_WU      17'h00043
`define EXE_BREAK       17'h00054
`define EXE_SYSCALL     17'h00056
`define EXE_IDLE        17'h00c91
`define EXE_INVTLB      17'h00c93
`define EXE_DBAR        17'h070e4
`define EXE_IBAR        17'h070e5

// 2RI12 format opcodes, instr[31:22]
`define EXE_SLTI        10'h008
`define EXE_SLTUI       10'h009
`define EXE_ADDI_W      10'h00a
`define EXE_ANDI        10'h00d
`define EXE_ORI         10'h00e
`define EXE_XORI        10'h00f

// ALU operation codes
`define EXE_NOP_OP      8'h00
`define EXE_ADD_OP      8'h01
`define EXE_SUB_OP      8'h02
`define EXE_SLT_OP      8'h03
`define EXE_SLTU_OP     8'h04
`define EXE_NOR_OP      8'h05
`define EXE_AND_OP      8'h06
`define EXE_OR_OP       8'h07
`define EXE_XOR_OP      8'h08
`define EXE_ORN_OP      8'h09
`define EXE_ANDN_OP     8'h0a
`define EXE_SLL_OP      8'h0b
`define EXE_SRL_OP      8'h0c
`define EXE_SRA_OP      8'h0d
`define EXE_MUL_OP      8'h0e
`define EXE_MULH_OP     8'h0f
`define EXE_MULHU_OP    8'h10
`define EXE_DIV_OP      8'h11
`define EXE_DIVU_OP     8'h12
`define EXE_MOD_OP      8'h13
`define EXE_MODU_OP     8'h14
`define EXE_IDLE_OP     8'h15
`define EXE_BREAK_OP    8'h16
`define EXE_SYSCALL_OP  8'h17
`define EXE_INVTLB_OP   8'h18

// Result class select
`define EXE_RES_NOP     3'b000
`define EXE_RES_ARITH   3'b001
`define EXE_RES_LOGIC   3'b010
`define EXE_RES_SHIFT   3'b011

`endif

/* core_types_pkg.sv */
`include "core_defines_macros.svh"

package core_types;

    // Instruction word as fetched from the instruction buffer
    typedef logic [`DATA_WIDTH-1:0] instr_t;

    // Immediates and register data
    typedef logic [`DATA_WIDTH-1:0] data_t;

    // General register index
    typedef logic [`GPR_ADDR_WIDTH-1:0] gpr_addr_t;

    // ALU control
    typedef logic [`ALU_OP_WIDTH-1:0] alu_op_t;
    typedef logic [`ALU_SEL_WIDTH-1:0] alu_sel_t;

    // Decode stage idle FSM
    typedef enum logic {
        DEC_RUN  = 1'b0,
        DEC_IDLE = 1'b1
    } idle_state_t;

endpackage

/* decode_result_if.sv */
`timescale 1ns/1ps

// One decoder's result, all fields zero when valid is low
interface decode_result_if
    import core_types::*;
();

    logic      valid;

    // Bit 0 is rj, bit 1 is rk
    logic [1:0] reg_read_valid;
    gpr_addr_t reg_read_addr_rj;
    gpr_addr_t reg_read_addr_rk;

    logic      reg_write_valid;
    gpr_addr_t reg_write_addr;

    logic      use_imm;
    data_t     imm;

    alu_op_t   aluop;
    alu_sel_t  alusel;

    // Special instructions
    logic      is_break;
    logic      is_syscall;
    logic      is_idle;

    modport producer (
        output valid, reg_read_valid, reg_read_addr_rj, reg_read_addr_rk,
        output reg_write_valid, reg_write_addr, use_imm, imm, aluop, alusel,
        output is_break, is_syscall, is_idle
    );

    modport consumer (
        input valid, reg_read_valid, reg_read_addr_rj, reg_read_addr_rk,
        input reg_write_valid, reg_write_addr, use_imm, imm, aluop, alusel,
        input is_break, is_syscall, is_idle
    );

endinterface

/* decoder_3r.sv */
`timescale 1ns/1ps
`include "core_defines_macros.svh"

// Three-register format {opcode[16:0], rk, rj, rd}
module decoder_3r
    import core_types::*;
(
    input instr_t               instr_i,
    decode_result_if.producer   res
);

    gpr_addr_t rd;
    gpr_addr_t rj;
    gpr_addr_t rk;

    assign rd = instr_i[4:0];
    assign rj = instr_i[9:5];
    assign rk = instr_i[14:10];

    always_comb begin
        // Common case reads rj and rk, writes rd
        res.valid            = 1'b1;
        res.reg_read_valid   = 2'b11;
        res.reg_read_addr_rj = rj;
        res.reg_read_addr_rk = rk;
        res.reg_write_valid  = 1'b1;
        res.reg_write_addr   = rd;
        res.use_imm          = 1'b0;
        res.imm              = '0;
        res.aluop            = `EXE_NOP_OP;
        res.alusel           = `EXE_RES_NOP;
        res.is_break         = 1'b0;
        res.is_syscall       = 1'b0;
        res.is_idle          = 1'b0;

        case (instr_i[31:15])
            `EXE_ADD_W:   {res.aluop, res.alusel} = {`EXE_ADD_OP,   `EXE_RES_ARITH};
            `EXE_SUB_W:   {res.aluop, res.alusel} = {`EXE_SUB_OP,   `EXE_RES_ARITH};
            `EXE_SLT:     {res.aluop, res.alusel} = {`EXE_SLT_OP,   `EXE_RES_ARITH};
            `EXE_SLTU:    {res.aluop, res.alusel} = {`EXE_SLTU_OP,  `EXE_RES_ARITH};
            `EXE_NOR:     {res.aluop, res.alusel} = {`EXE_NOR_OP,   `EXE_RES_LOGIC};
            `EXE_AND:     {res.aluop, res.alusel} = {`EXE_AND_OP,   `EXE_RES_LOGIC};
            `EXE_OR:      {res.aluop, res.alusel} = {`EXE_OR_OP,    `EXE_RES_LOGIC};
            `EXE_XOR:     {res.aluop, res.alusel} = {`EXE_XOR_OP,   `EXE_RES_LOGIC};
            `EXE_ORN:     {res.aluop, res.alusel} = {`EXE_ORN_OP,   `EXE_RES_LOGIC};
            `EXE_ANDN:    {res.aluop, res.alusel} = {`EXE_ANDN_OP,  `EXE_RES_LOGIC};
            `EXE_SLL_W:   {res.aluop, res.alusel} = {`EXE_SLL_OP,   `EXE_RES_SHIFT};
            `EXE_SRL_W:   {res.aluop, res.alusel} = {`EXE_SRL_OP,   `EXE_RES_SHIFT};
            `EXE_SRA_W:   {res.aluop, res.alusel} = {`EXE_SRA_OP,   `EXE_RES_SHIFT};
            `EXE_MUL_W:   {res.aluop, res.alusel} = {`EXE_MUL_OP,   `EXE_RES_ARITH};
            `EXE_MULH_W:  {res.aluop, res.alusel} = {`EXE_MULH_OP,  `EXE_RES_ARITH};
            `EXE_MULH_WU: {res.aluop, res.alusel} = {`EXE_MULHU_OP, `EXE_RES_ARITH};
            `EXE_DIV_W:   {res.aluop, res.alusel} = {`EXE_DIV_OP,   `EXE_RES_ARITH};
            `EXE_DIV_WU:  {res.aluop, res.alusel} = {`EXE_DIVU_OP,  `EXE_RES_ARITH};
            `EXE_MOD_W:   {res.aluop, res.alusel} = {`EXE_MOD_OP,   `EXE_RES_ARITH};
            `EXE_MOD_WU:  {res.aluop, res.alusel} = {`EXE_MODU_OP,  `EXE_RES_ARITH};
            `EXE_BREAK, `EXE_SYSCALL, `EXE_IDLE, `EXE_DBAR, `EXE_IBAR: begin
                // No general registers touched here
                res.reg_read_valid   = 2'b00;
                res.reg_read_addr_rj = '0;
                res.reg_read_addr_rk = '0;
                res.reg_write_valid  = 1'b0;
                res.reg_write_addr   = '0;
                res.is_break         = (instr_i[31:15] == `EXE_BREAK);
                res.is_syscall       = (instr_i[31:15] == `EXE_SYSCALL);
                res.is_idle          = (instr_i[31:15] == `EXE_IDLE);
                if (res.is_break) begin
                    res.aluop = `EXE_BREAK_OP;
                end else if (res.is_syscall) begin
                    res.aluop = `EXE_SYSCALL_OP;
                end else if (res.is_idle) begin
                    res.aluop = `EXE_IDLE_OP;
                end
            end
            `EXE_INVTLB: begin
                // rd field is an op selector, not a register
                res.aluop           = `EXE_INVTLB_OP;
                res.use_imm         = 1'b1;
                res.imm             = {{(`DATA_WIDTH-`GPR_ADDR_WIDTH){1'b0}}, rd};
                res.reg_write_valid = 1'b0;
                res.reg_write_addr  = '0;
            end
            default: begin
                // Not a 3R word
                res.valid            = 1'b0;
                res.reg_read_valid   = 2'b00;
                res.reg_read_addr_rj = '0;
                res.reg_read_addr_rk = '0;
                res.reg_write_valid  = 1'b0;
                res.reg_write_addr   = '0;
            end
        endcase
    end

endmodule

/* decoder_2ri12.sv */
`timescale 1ns/1ps
`include "core_defines_macros.svh"

// Register plus 12-bit immediate ALU format {opcode[9:0], si12, rj, rd}
module decoder_2ri12
    import core_types::*;
(
    input instr_t               instr_i,
    decode_result_if.producer   res
);

    logic [11:0] imm12;
    data_t       imm_sext;
    data_t       imm_zext;

    assign imm12    = instr_i[21:10];
    assign imm_sext = {{(`DATA_WIDTH-12){imm12[11]}}, imm12};
    assign imm_zext = {{(`DATA_WIDTH-12){1'b0}}, imm12};

    always_comb begin
        res.valid            = 1'b1;
        res.reg_read_valid   = 2'b01;
        res.reg_read_addr_rj = instr_i[9:5];
        res.reg_read_addr_rk = '0;
        res.reg_write_valid  = 1'b1;
        res.reg_write_addr   = instr_i[4:0];
        res.use_imm          = 1'b1;
        res.imm              = imm_sext;
        res.aluop            = `EXE_NOP_OP;
        res.alusel           = `EXE_RES_NOP;
        // Never special in this format
        res.is_break         = 1'b0;
        res.is_syscall       = 1'b0;
        res.is_idle          = 1'b0;

        case (instr_i[31:22])
            `EXE_ADDI_W: {res.aluop, res.alusel} = {`EXE_ADD_OP,  `EXE_RES_ARITH};
            `EXE_SLTI:   {res.aluop, res.alusel} = {`EXE_SLT_OP,  `EXE_RES_ARITH};
            `EXE_SLTUI:  {res.aluop, res.alusel} = {`EXE_SLTU_OP, `EXE_RES_ARITH};
            `EXE_ANDI, `EXE_ORI, `EXE_XORI: begin
                // Logic immediates are zero-extended
                res.imm    = imm_zext;
                res.alusel = `EXE_RES_LOGIC;
                case (instr_i[31:22])
                    `EXE_ANDI: res.aluop = `EXE_AND_OP;
                    `EXE_ORI:  res.aluop = `EXE_OR_OP;
                    default:   res.aluop = `EXE_XOR_OP;
                endcase
            end
            default: begin
                res.valid            = 1'b0;
                res.reg_read_valid   = 2'b00;
                res.reg_read_addr_rj = '0;
                res.reg_write_valid  = 1'b0;
                res.reg_write_addr   = '0;
                res.use_imm          = 1'b0;
                res.imm              = '0;
            end
        endcase
    end

endmodule

/* decode_merge.sv */
`timescale 1ns/1ps

module decode_merge
    import core_types::*;
(
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                instr_valid_i,
    input  logic                stall_i,
    input  logic                wake_i,
    decode_result_if.consumer   r3,
    decode_result_if.consumer   r2i,
    output logic                dec_valid_o,
    output logic [1:0]          reg_read_valid_o,
    output gpr_addr_t           reg_read_addr_rj_o,
    output gpr_addr_t           reg_read_addr_rk_o,
    output logic                reg_write_valid_o,
    output gpr_addr_t           reg_write_addr_o,
    output logic                use_imm_o,
    output data_t               imm_o,
    output alu_op_t             aluop_o,
    output alu_sel_t            alusel_o,
    output logic                break_o,
    output logic                syscall_o,
    output logic                ine_o,
    output logic                idle_o
);

    idle_state_t state;
    logic        accept;
    logic        take_idle;

    assign accept    = instr_valid_i && !stall_i && (state == DEC_RUN);
    assign take_idle = accept && r3.valid && r3.is_idle;
    assign idle_o    = (state == DEC_IDLE);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= DEC_RUN;
        end else if (state == DEC_IDLE && wake_i) begin
            state <= DEC_RUN;
        end else if (take_idle) begin
            state <= DEC_IDLE;
        end
    end

    // Output register; an accepted idle word shows up as idle_o only
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o        <= 1'b0;
            reg_read_valid_o   <= 2'b00;
            reg_read_addr_rj_o <= '0;
            reg_read_addr_rk_o <= '0;
            reg_write_valid_o  <= 1'b0;
            reg_write_addr_o   <= '0;
            use_imm_o          <= 1'b0;
            imm_o              <= '0;
            aluop_o            <= '0;
            alusel_o           <= '0;
            break_o            <= 1'b0;
            syscall_o          <= 1'b0;
            ine_o              <= 1'b0;
        end else if (!stall_i) begin
            if (accept && !take_idle) begin
                dec_valid_o <= 1'b1;
                ine_o       <= !r3.valid && !r2i.valid;
                if (r3.valid) begin
                    reg_read_valid_o   <= r3.reg_read_valid;
                    reg_read_addr_rj_o <= r3.reg_read_addr_rj;
                    reg_read_addr_rk_o <= r3.reg_read_addr_rk;
                    reg_write_valid_o  <= r3.reg_write_valid;
                    reg_write_addr_o   <= r3.reg_write_addr;
                    use_imm_o          <= r3.use_imm;
                    imm_o              <= r3.imm;
                    aluop_o            <= r3.aluop;
                    alusel_o           <= r3.alusel;
                    break_o            <= r3.is_break;
                    syscall_o          <= r3.is_syscall;
                end else begin
                    // Zero fields from 2RI12 when neither decoder matched
                    reg_read_valid_o   <= r2i.reg_read_valid;
                    reg_read_addr_rj_o <= r2i.reg_read_addr_rj;
                    reg_read_addr_rk_o <= r2i.reg_read_addr_rk;
                    reg_write_valid_o  <= r2i.reg_write_valid;
                    reg_write_addr_o   <= r2i.reg_write_addr;
                    use_imm_o          <= r2i.use_imm;
                    imm_o              <= r2i.imm;
                    aluop_o            <= r2i.aluop;
                    alusel_o           <= r2i.alusel;
                    break_o            <= r2i.is_break;
                    syscall_o          <= r2i.is_syscall;
                end
            end else begin
                dec_valid_o        <= 1'b0;
                reg_read_valid_o   <= 2'b00;
                reg_read_addr_rj_o <= '0;
                reg_read_addr_rk_o <= '0;
                reg_write_valid_o  <= 1'b0;
                reg_write_addr_o   <= '0;
                use_imm_o          <= 1'b0;
                imm_o              <= '0;
                aluop_o            <= '0;
                alusel_o           <= '0;
                break_o            <= 1'b0;
                syscall_o          <= 1'b0;
                ine_o              <= 1'b0;
            end
        end
    end

    // The two formats have disjoint opcode spaces
    assert property (@(posedge clk) disable iff (!rst_n_i)
        !(r3.valid && r2i.valid));

    // Idle stage never presents a decoded word
    assert property (@(posedge clk) disable iff (!rst_n_i)
        !(idle_o && dec_valid_o));

endmodule

/* id_stage.sv */
`timescale 1ns/1ps

module id_stage
    import core_types::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        instr_valid_i,
    input  instr_t      instr_i,
    input  logic        stall_i,
    input  logic        wake_i,
    output logic        dec_valid_o,
    output logic [1:0]  reg_read_valid_o,
    output gpr_addr_t   reg_read_addr_rj_o,
    output gpr_addr_t   reg_read_addr_rk_o,
    output logic        reg_write_valid_o,
    output gpr_addr_t   reg_write_addr_o,
    output logic        use_imm_o,
    output data_t       imm_o,
    output alu_op_t     aluop_o,
    output alu_sel_t    alusel_o,
    output logic        break_o,
    output logic        syscall_o,
    output logic        ine_o,
    output logic        idle_o
);

    decode_result_if if_3r ();
    decode_result_if if_2ri12 ();

    // Both decoders see the same word
    decoder_3r u_decoder_3r (
        .instr_i (instr_i),
        .res     (if_3r.producer)
    );

    decoder_2ri12 u_decoder_2ri12 (
        .instr_i (instr_i),
        .res     (if_2ri12.producer)
    );

    decode_merge u_decode_merge (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .instr_valid_i      (instr_valid_i),
        .stall_i            (stall_i),
        .wake_i             (wake_i),
        .r3                 (if_3r.consumer),
        .r2i                (if_2ri12.consumer),
        .dec_valid_o        (dec_valid_o),
        .reg_read_valid_o   (reg_read_valid_o),
        .reg_read_addr_rj_o (reg_read_addr_rj_o),
        .reg_read_addr_rk_o (reg_read_addr_rk_o),
        .reg_write_valid_o  (reg_write_valid_o),
        .reg_write_addr_o   (reg_write_addr_o),
        .use_imm_o          (use_imm_o),
        .imm_o              (imm_o),
        .aluop_o            (aluop_o),
        .alusel_o           (alusel_o),
        .break_o            (break_o),
        .syscall_o          (syscall_o),
        .ine_o              (ine_o),
        .idle_o             (idle_o)
    );

endmodule

/* tb_id_stage.sv */
`timescale 1ns/1ps
`include "core_defines_macros.svh"

module tb_id_stage;

    localparam int HALF_PERIOD  = 20;
    localparam int CLK_PERIOD   = 2 * HALF_PERIOD;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_VECS     = 64;
    localparam int NUM_FIELDS   = 14;
    localparam int NUM_COLUMNS  = 19;
    // Expected idle_o is the last column of a vector
    localparam int IDLE_FIELD   = 13;

    logic        clk;
    logic        rst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        stall_i;
    logic        wake_i;
    logic        dec_valid_o;
    logic [1:0]  reg_read_valid_o;
    logic [4:0]  reg_read_addr_rj_o;
    logic [4:0]  reg_read_addr_rk_o;
    logic        reg_write_valid_o;
    logic [4:0]  reg_write_addr_o;
    logic        use_imm_o;
    logic [31:0] imm_o;
    logic [7:0]  aluop_o;
    logic [2:0]  alusel_o;
    logic        break_o;
    logic        syscall_o;
    logic        ine_o;
    logic        idle_o;

    // Vectors loaded from the stimulus file
    string       vec_name  [MAX_VECS];
    logic        vec_valid [MAX_VECS];
    logic [31:0] vec_instr [MAX_VECS];
    logic        vec_stall [MAX_VECS];
    logic        vec_wake  [MAX_VECS];
    logic [31:0] vec_exp   [MAX_VECS][NUM_FIELDS];

    logic [31:0] cur_exp [NUM_FIELDS];
    int          vec_count;
    int          tests_passed;
    int          tests_failed;

    id_stage uut (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .instr_valid_i      (instr_valid_i),
        .instr_i            (instr_i),
        .stall_i            (stall_i),
        .wake_i             (wake_i),
        .dec_valid_o        (dec_valid_o),
        .reg_read_valid_o   (reg_read_valid_o),
        .reg_read_addr_rj_o (reg_read_addr_rj_o),
        .reg_read_addr_rk_o (reg_read_addr_rk_o),
        .reg_write_valid_o  (reg_write_valid_o),
        .reg_write_addr_o   (reg_write_addr_o),
        .use_imm_o          (use_imm_o),
        .imm_o              (imm_o),
        .aluop_o            (aluop_o),
        .alusel_o           (alusel_o),
        .break_o            (break_o),
        .syscall_o          (syscall_o),
        .ine_o              (ine_o),
        .idle_o             (idle_o)
    );

    always #HALF_PERIOD clk = ~clk;

    function automatic string field_label(input int f);
        case (f)
            0:       return "dec_valid_o";
            1:       return "reg_read_valid_o";
            2:       return "reg_read_addr_rj_o";
            3:       return "reg_read_addr_rk_o";
            4:       return "reg_write_valid_o";
            5:       return "reg_write_addr_o";
            6:       return "use_imm_o";
            7:       return "imm_o";
            8:       return "aluop_o";
            9:       return "alusel_o";
            10:      return "break_o";
            11:      return "syscall_o";
            12:      return "ine_o";
            default: return "idle_o";
        endcase
    endfunction

    task automatic load_vectors(output bit ok);
        int    fd;
        int    n;
        int    bad_lines;
        string line;
        string name;
        bad_lines = 0;
        vec_count = 0;
        fd = $fopen("id_stage_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open id_stage_input.txt");
            ok = 1'b0;
        end else begin
            while (!$feof(fd) && vec_count < MAX_VECS) begin
                line = "";
                n = $fgets(line, fd);
                // Lines starting with # describe the columns
                if (n > 0 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, vec_valid[vec_count], vec_instr[vec_count],
                        vec_stall[vec_count], vec_wake[vec_count],
                        vec_exp[vec_count][0], vec_exp[vec_count][1], vec_exp[vec_count][2],
                        vec_exp[vec_count][3], vec_exp[vec_count][4], vec_exp[vec_count][5],
                        vec_exp[vec_count][6], vec_exp[vec_count][7], vec_exp[vec_count][8],
                        vec_exp[vec_count][9], vec_exp[vec_count][10], vec_exp[vec_count][11],
                        vec_exp[vec_count][12], vec_exp[vec_count][13]);
                    if (n == NUM_COLUMNS) begin
                        vec_name[vec_count] = name;
                        vec_count++;
                    end else if (n > 0) begin
                        $display("Malformed line in id_stage_input.txt: %s", line);
                        bad_lines++;
                    end
                end
            end
            $fclose(fd);
            ok = (bad_lines == 0) && (vec_count > 0);
        end
    endtask

    task automatic check_outputs(input string name);
        logic [31:0] act [NUM_FIELDS];
        int          f;
        int          bad;
        act[0]  = 32'(dec_valid_o);
        act[1]  = 32'(reg_read_valid_o);
        act[2]  = 32'(reg_read_addr_rj_o);
        act[3]  = 32'(reg_read_addr_rk_o);
        act[4]  = 32'(reg_write_valid_o);
        act[5]  = 32'(reg_write_addr_o);
        act[6]  = 32'(use_imm_o);
        act[7]  = imm_o;
        act[8]  = 32'(aluop_o);
        act[9]  = 32'(alusel_o);
        act[10] = 32'(break_o);
        act[11] = 32'(syscall_o);
        act[12] = 32'(ine_o);
        act[13] = 32'(idle_o);
        bad = 0;
        for (f = 0; f < NUM_FIELDS; f++) begin
            assert (act[f] === cur_exp[f]) else begin
                $display("mismatch %s %s: expected %h, actual %h",
                    name, field_label(f), cur_exp[f], act[f]);
                bad++;
            end
        end
        if (bad == 0) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d wrong fields", name, bad);
        end
    endtask

    // Called on a falling edge, result checked at the next falling edge
    task automatic apply_vector(input string name, input logic valid,
                                input logic [31:0] instr, input logic stall,
                                input logic wake);
        instr_valid_i = valid;
        instr_i       = instr;
        stall_i       = stall;
        wake_i        = wake;
        @(posedge clk);
        @(negedge clk);
        check_outputs(name);
    endtask

    // Even fillers are add.w, odd ones addi.w with a random immediate
    task automatic run_filler(input int k);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [11:0] imm12;
        logic [31:0] word;
        int          f;
        r     = $urandom();
        rd    = r[4:0];
        rj    = r[9:5];
        rk    = r[14:10];
        imm12 = r[26:15];
        for (f = 0; f < NUM_FIELDS; f++) begin
            cur_exp[f] = '0;
        end
        cur_exp[0] = 32'd1;
        cur_exp[2] = 32'(rj);
        cur_exp[4] = 32'd1;
        cur_exp[5] = 32'(rd);
        cur_exp[8] = 32'(`EXE_ADD_OP);
        cur_exp[9] = 32'(`EXE_RES_ARITH);
        if (k % 2 == 0) begin
            word       = {`EXE_ADD_W, rk, rj, rd};
            cur_exp[1] = 32'd3;
            cur_exp[3] = 32'(rk);
        end else begin
            word       = {`EXE_ADDI_W, imm12, rj, rd};
            cur_exp[1] = 32'd1;
            cur_exp[6] = 32'd1;
            cur_exp[7] = {{20{imm12[11]}}, imm12};
        end
        apply_vector($sformatf("filler_%0d", k), 1'b1, word, 1'b0, 1'b0);
    endtask

    initial begin
        bit load_ok;
        int i;
        int f;
        int filler_count;
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        stall_i       = 1'b0;
        wake_i        = 1'b0;
        tests_passed  = 0;
        tests_failed  = 0;
        filler_count  = 0;
        void'($urandom(32'hcfa4_795b));
        load_vectors(load_ok);
        if (!load_ok) begin
            $display("No usable vectors could be read from id_stage_input.txt");
            $display("Checks failed");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            // Everything cleared while in reset
            for (f = 0; f < NUM_FIELDS; f++) begin
                cur_exp[f] = '0;
            end
            check_outputs("reset");
            rst_n_i = 1'b1;
            for (i = 0; i < vec_count; i++) begin
                for (f = 0; f < NUM_FIELDS; f++) begin
                    cur_exp[f] = vec_exp[i][f];
                end
                apply_vector(vec_name[i], vec_valid[i], vec_instr[i],
                             vec_stall[i], vec_wake[i]);
                // No filler inside a stall hold or while the stage sits idle
                if (i + 1 < vec_count && vec_exp[i][IDLE_FIELD] == 32'd0
                        && !vec_stall[i + 1]) begin
                    run_filler(filler_count);
                    filler_count++;
                end
            end
            $display("Tests run: %0d, passed: %0d, failed: %0d",
                tests_passed + tests_failed, tests_passed, tests_failed);
            if (tests_failed == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    // Watchdog, room for every vector plus one filler each
    initial begin
        int timeout_ns;
        wait (vec_count > 0);
        timeout_ns = (2 * vec_count + RESET_CYCLES + 40) * CLK_PERIOD;
        #(timeout_ns);
        $display("Timeout after %0d ns, the test sequence did not finish", timeout_ns);
        $display("Checks failed");
        $finish;
    end

endmodule

/* id_stage_input.txt */
# name instr_valid instr stall wake, then expected: dec_valid rd_valid rj rk wr_valid rd
# use_imm imm aluop alusel break syscall ine idle (all hex, outputs one clock later)
add_w         1 00100c41 0 0  1 3 02 03 1 01 0 00000000 01 1 0 0 0 0
sub_w         1 00111486 0 0  1 3 04 05 1 06 0 00000000 02 1 0 0 0 0
slt           1 00121d09 0 0  1 3 08 07 1 09 0 00000000 03 1 0 0 0 0
sltu          1 00128421 0 0  1 3 01 01 1 01 0 00000000 04 1 0 0 0 0
nor           1 0014296c 0 0  1 3 0b 0a 1 0c 0 00000000 05 2 0 0 0 0
and           1 0014ffdd 0 0  1 3 1e 1f 1 1d 0 00000000 06 2 0 0 0 0
or            1 00150864 0 0  1 3 03 02 1 04 0 00000000 07 2 0 0 0 0
xor           1 00158000 0 0  1 3 00 00 1 00 0 00000000 08 2 0 0 0 0
orn           1 001618e8 0 0  1 3 07 06 1 08 0 00000000 09 2 0 0 0 0
andn          1 0016a54b 0 0  1 3 0a 09 1 0b 0 00000000 0a 2 0 0 0 0
sll_w         1 001731ae 0 0  1 3 0d 0c 1 0e 0 00000000 0b 3 0 0 0 0
srl_w         1 0017be11 0 0  1 3 10 0f 1 11 0 00000000 0c 3 0 0 0 0
sra_w         1 00184a74 0 0  1 3 13 12 1 14 0 00000000 0d 3 0 0 0 0
mul_w         1 001c56d7 0 0  1 3 16 15 1 17 0 00000000 0e 1 0 0 0 0
mulh_w        1 001c8443 0 0  1 3 02 01 1 03 0 00000000 0f 1 0 0 0 0
mulh_wu       1 001d10a6 0 0  1 3 05 04 1 06 0 00000000 10 1 0 0 0 0
div_w         1 00201d09 0 0  1 3 08 07 1 09 0 00000000 11 1 0 0 0 0
div_wu        1 00210443 0 0  1 3 02 01 1 03 0 00000000 12 1 0 0 0 0
mod_w         1 0020e33a 0 0  1 3 19 18 1 1a 0 00000000 13 1 0 0 0 0
mod_wu        1 0021ef93 0 0  1 3 1c 1b 1 13 0 00000000 14 1 0 0 0 0
addi_w        1 02a00041 0 0  1 1 02 00 1 01 1 fffff800 01 1 0 0 0 0
slti          1 021ffc64 0 0  1 1 03 00 1 04 1 000007ff 03 1 0 0 0 0
sltui         1 027ffca6 0 0  1 1 05 00 1 06 1 ffffffff 04 1 0 0 0 0
andi          1 036af0e8 0 0  1 1 07 00 1 08 1 00000abc 06 2 0 0 0 0
ori           1 03a0012a 0 0  1 1 09 00 1 0a 1 00000800 07 2 0 0 0 0
xori          1 03fc3d6c 0 0  1 1 0b 00 1 0c 1 00000f0f 08 2 0 0 0 0
break         1 002a0005 0 0  1 0 00 00 0 00 0 00000000 16 0 1 0 0 0
syscall       1 002b0011 0 0  1 0 00 00 0 00 0 00000000 17 0 0 1 0 0
dbar          1 38720000 0 0  1 0 00 00 0 00 0 00000000 00 0 0 0 0 0
ibar          1 38728000 0 0  1 0 00 00 0 00 0 00000000 00 0 0 0 0 0
invtlb        1 06498c45 0 0  1 3 02 03 0 00 1 00000005 18 0 0 0 0 0
unknown       1 ffffffff 0 0  1 0 00 00 0 00 0 00000000 00 0 0 0 1 0
bubble        0 00100c41 0 0  0 0 00 00 0 00 0 00000000 00 0 0 0 0 0
stall_pre     1 00100c41 0 0  1 3 02 03 1 01 0 00000000 01 1 0 0 0 0
stall_hold    1 00111486 1 0  1 3 02 03 1 01 0 00000000 01 1 0 0 0 0
stall_hold2   0 00000000 1 0  1 3 02 03 1 01 0 00000000 01 1 0 0 0 0
stall_release 1 00111486 0 0  1 3 04 05 1 06 0 00000000 02 1 0 0 0 0
idle          1 06488000 0 0  0 0 00 00 0 00 0 00000000 00 0 0 0 0 1
idle_ignore   1 00100c41 0 0  0 0 00 00 0 00 0 00000000 00 0 0 0 0 1
idle_wake     0 00000000 0 1  0 0 00 00 0 00 0 00000000 00 0 0 0 0 0
after_wake    1 0014296c 0 0  1 3 0b 0a 1 0c 0 00000000 05 2 0 0 0 0

/* verilog.f */
+incdir+.
core_types_pkg.sv
decode_result_if.sv
decoder_3r.sv
decoder_2ri12.sv
decode_merge.sv
id_stage.sv
tb_id_stage.sv

/* run_sim.sh */
#!/bin/sh
# Builds the ID stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_id_stage -o tb_id_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_id_stage > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "All checks passed" "$log_file"; then
    exit 0
fi
echo "Pass message not found in $log_file"
exit 1
